// File: src/cache_pkg.sv
`default_nettype none

package cache_pkg;

	localparam int NODES = 4;

	localparam int TAG_BITS = 5;
	localparam int INDEX_BITS = 3;
	localparam int ADDR_BITS = TAG_BITS + INDEX_BITS;	// tag above index
	localparam int LINES = 1 << INDEX_BITS;

	localparam int DATA_BITS = 32;	// one word per line

	// hop counter, loaded on send and decremented per forward
	localparam int TTL_BITS = 2;
	localparam logic [TTL_BITS-1:0] TTL_MAX = 2'd3;	// NODES - 1 forwards
	localparam logic [TTL_BITS-1:0] TTL_END = 2'd0;	// back at the origin

	typedef logic [TAG_BITS-1:0] addr_tag;
	typedef logic [INDEX_BITS-1:0] addr_index;
	typedef logic [DATA_BITS-1:0] line;

	typedef struct packed {
		addr_tag tag;
		addr_index index;
		logic [TTL_BITS-1:0] ttl;
		line data;	// only meaningful on a reply
		logic read;
		logic inval;
		logic reply;	// read packet already answered
	} ring_req;

	typedef struct packed {
		logic write;
		logic [ADDR_BITS-1:0] addr;
		line wdata;
	} core_req;

	typedef struct packed {
		logic found;	// low when no node held the line
		line rdata;
	} core_resp;

endpackage

`default_nettype wire

// File: src/cache_line_store.sv
`default_nettype none

module cache_line_store (
	input  logic clk,
	input  logic rst_n,

	input  cache_pkg::addr_index lookup_index,
	input  cache_pkg::addr_tag lookup_tag,
	output logic hit,
	output cache_pkg::line rd_data,

	input  cache_pkg::addr_index snoop_index,
	input  cache_pkg::addr_tag snoop_tag,
	output logic snoop_hit,
	output cache_pkg::line snoop_data,

	input  logic wr_en,
	input  cache_pkg::addr_index wr_index,
	input  cache_pkg::addr_tag wr_tag,
	input  cache_pkg::line wr_data,

	input  logic inval_en,
	input  cache_pkg::addr_index inval_index,
	input  cache_pkg::addr_tag inval_tag
);

	cache_pkg::addr_tag tags [cache_pkg::LINES];
	cache_pkg::line data [cache_pkg::LINES];
	logic [cache_pkg::LINES-1:0] valid;

	// core port
	assign hit = valid[lookup_index] && (tags[lookup_index] == lookup_tag);
	assign rd_data = data[lookup_index];

	// snoop port, addressed by the held ring packet
	assign snoop_hit = valid[snoop_index] && (tags[snoop_index] == snoop_tag);
	assign snoop_data = data[snoop_index];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
		end else begin
			if (inval_en && tags[inval_index] == inval_tag)
				valid[inval_index] <= 1'b0;	// other tag in that slot survives

			if (wr_en)
				valid[wr_index] <= 1'b1;	// write wins on a same-cycle clash
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			tags[wr_index] <= wr_tag;
			data[wr_index] <= wr_data;
		end
	end

endmodule

`default_nettype wire

// File: src/cache_ring.sv
`default_nettype none

module cache_ring (
	input  logic clk,
	input  logic rst_n,

	input  cache_pkg::addr_tag core_tag,
	input  cache_pkg::addr_index core_index,

	input  cache_pkg::ring_req in_data,
	input  logic in_data_valid,
	output logic in_data_ready,

	input  logic out_data_ready,
	output cache_pkg::ring_req out_data,
	output logic out_data_valid,

	input  cache_pkg::line data_rd,	// local line for a reply

	input  logic send,
	input  logic send_read,
	input  logic send_inval,
	input  logic set_reply,
	output logic out_stall,
	output logic in_hold_valid,
	output logic last_hop,
	output cache_pkg::ring_req in_hold
);

	cache_pkg::ring_req send_data;
	cache_pkg::ring_req fwd_data;
	cache_pkg::ring_req stall_data;
	cache_pkg::ring_req out_data_next;

	assign in_data_ready = !out_stall;	// hold register frozen while stalled
	assign last_hop = in_hold.ttl == cache_pkg::TTL_END;

	assign out_data_next = send ? send_data : fwd_data;
	assign out_data = out_stall ? stall_data : out_data_next;
	assign out_data_valid = out_stall || send || (in_hold_valid && !last_hop && in_data_ready);

	// new packet from the local controller
	always_comb begin
		send_data.tag = core_tag;
		send_data.index = core_index;
		send_data.ttl = cache_pkg::TTL_MAX;
		send_data.data = fwd_data.data;	// filled in later by a reply, if any
		send_data.read = send_read;
		send_data.inval = send_inval;
		send_data.reply = 1'b0;
	end

	always_comb begin
		fwd_data = in_hold;
		fwd_data.ttl = in_hold.ttl - 2'd1;	// one hop done

		if (set_reply) begin
			fwd_data.data = data_rd;
			fwd_data.reply = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_hold_valid <= 1'b0;
			out_stall <= 1'b0;
		end else begin
			if (in_data_ready)
				in_hold_valid <= in_data_valid;

			out_stall <= out_data_valid && !out_data_ready;	// downstream refused
		end
	end

	always_ff @(posedge clk) begin
		if (in_data_ready)
			in_hold <= in_data;

		if (!out_stall)
			stall_data <= out_data_next;	// copy to re-present under stall
	end

endmodule

`default_nettype wire

// File: src/cache_node_ctrl.sv
`default_nettype none

module cache_node_ctrl (
	input  logic clk,
	input  logic rst_n,

	input  logic core_req_valid,
	input  cache_pkg::core_req core_req,
	output logic core_ready,
	output logic core_done,
	output cache_pkg::core_resp core_resp,

	input  logic hit,
	input  cache_pkg::line rd_data,
	input  logic snoop_hit,
	input  cache_pkg::line snoop_data,
	output cache_pkg::addr_tag lookup_tag,
	output cache_pkg::addr_index lookup_index,

	output logic wr_en,
	output cache_pkg::addr_index wr_index,
	output cache_pkg::addr_tag wr_tag,
	output cache_pkg::line wr_data,
	output logic inval_en,
	output cache_pkg::addr_index inval_index,
	output cache_pkg::addr_tag inval_tag,

	input  cache_pkg::ring_req in_hold,
	input  logic in_hold_valid,
	input  logic last_hop,
	input  logic in_data_ready,
	input  logic out_stall,
	output logic send,
	output logic send_read,
	output logic send_inval,
	output logic set_reply,
	output cache_pkg::addr_tag core_tag,
	output cache_pkg::addr_index core_index,
	output cache_pkg::line data_rd
);

	typedef enum logic [1:0] {
		idle,
		wait_send,
		wait_return
	} ctrl_state;

	ctrl_state state;
	cache_pkg::core_req pending;	// request in flight

	logic accept;
	logic pass_through;
	logic consume;
	logic fill;
	logic strobe_write;

	assign accept = core_req_valid && core_ready;
	assign pass_through = in_hold_valid && !last_hop && in_data_ready;	// forwarded this cycle
	// only our own packet can come back with ttl at the end
	assign consume = in_hold_valid && last_hop && in_data_ready && (state == wait_return);
	assign fill = consume && in_hold.reply;
	assign strobe_write = accept && core_req.write;

	assign core_ready = (state == idle) && !core_done;

	// core lookup straight off the strobe
	assign lookup_tag = core_req.addr[cache_pkg::ADDR_BITS-1 -: cache_pkg::TAG_BITS];
	assign lookup_index = core_req.addr[cache_pkg::INDEX_BITS-1:0];

	// local write on the strobe, fill on a returning reply
	assign wr_en = strobe_write || fill;
	assign wr_index = fill ? in_hold.index : lookup_index;
	assign wr_tag = fill ? in_hold.tag : lookup_tag;
	assign wr_data = fill ? in_hold.data : core_req.wdata;

	// snooping of packets from other nodes
	assign set_reply = pass_through && in_hold.read && !in_hold.reply && snoop_hit;
	assign data_rd = snoop_data;
	assign inval_en = pass_through && in_hold.inval;
	assign inval_index = in_hold.index;
	assign inval_tag = in_hold.tag;

	// forwarding has priority over a new packet
	assign send = (state == wait_send) && !out_stall && !pass_through;
	assign send_read = !pending.write;
	assign send_inval = pending.write;
	assign core_tag = pending.addr[cache_pkg::ADDR_BITS-1 -: cache_pkg::TAG_BITS];
	assign core_index = pending.addr[cache_pkg::INDEX_BITS-1:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			core_done <= 1'b0;
		end else begin
			core_done <= 1'b0;
			case (state)
				idle: begin
					if (accept && !core_req.write && hit)
						core_done <= 1'b1;	// local hit, answered next cycle
					else if (accept)
						state <= wait_send;
				end
				wait_send: begin
					if (send)
						state <= wait_return;
				end
				wait_return: begin
					if (consume) begin
						state <= idle;
						core_done <= 1'b1;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pending <= core_req;
			core_resp.found <= hit;
			core_resp.rdata <= rd_data;
		end else if (consume) begin
			core_resp.found <= in_hold.reply;	// low for inval and unanswered read
			core_resp.rdata <= in_hold.reply ? in_hold.data : '0;
		end
	end

endmodule

`default_nettype wire

// File: src/cache_node.sv
`default_nettype none

module cache_node (
	input  logic clk,
	input  logic rst_n,

	input  logic core_req_valid,
	input  cache_pkg::core_req core_req,
	output logic core_ready,
	output logic core_done,
	output cache_pkg::core_resp core_resp,

	input  cache_pkg::ring_req in_data,
	input  logic in_data_valid,
	output logic in_data_ready,
	output cache_pkg::ring_req out_data,
	output logic out_data_valid,
	input  logic out_data_ready
);

	cache_pkg::addr_tag lookup_tag, wr_tag, inval_tag, core_tag;
	cache_pkg::addr_index lookup_index, wr_index, inval_index, core_index;
	cache_pkg::line rd_data, snoop_data, wr_data, data_rd;
	cache_pkg::ring_req in_hold;
	logic hit, snoop_hit, wr_en, inval_en;
	logic in_hold_valid, last_hop, out_stall;
	logic send, send_read, send_inval, set_reply;

	cache_line_store store (
		.clk, .rst_n,
		.lookup_index, .lookup_tag, .hit, .rd_data,
		.snoop_index(in_hold.index),	// snoop whatever sits in the hold register
		.snoop_tag(in_hold.tag),
		.snoop_hit, .snoop_data,
		.wr_en, .wr_index, .wr_tag, .wr_data,
		.inval_en, .inval_index, .inval_tag
	);

	cache_node_ctrl ctrl (
		.clk, .rst_n,
		.core_req_valid, .core_req, .core_ready, .core_done, .core_resp,
		.hit, .rd_data, .snoop_hit, .snoop_data, .lookup_tag, .lookup_index,
		.wr_en, .wr_index, .wr_tag, .wr_data,
		.inval_en, .inval_index, .inval_tag,
		.in_hold, .in_hold_valid, .last_hop, .in_data_ready, .out_stall,
		.send, .send_read, .send_inval, .set_reply,
		.core_tag, .core_index, .data_rd
	);

	cache_ring stop (
		.clk, .rst_n,
		.core_tag, .core_index,
		.in_data, .in_data_valid, .in_data_ready,
		.out_data_ready, .out_data, .out_data_valid,
		.data_rd,
		.send, .send_read, .send_inval, .set_reply,
		.out_stall, .in_hold_valid, .last_hop, .in_hold
	);

endmodule

`default_nettype wire

// File: src/ring_cache_top.sv
`default_nettype none

module ring_cache_top (
	input  logic clk,
	input  logic rst_n,

	input  logic [cache_pkg::NODES-1:0] core_req_valid,
	input  cache_pkg::core_req core_req [cache_pkg::NODES],
	output logic [cache_pkg::NODES-1:0] core_ready,
	output logic [cache_pkg::NODES-1:0] core_done,
	output cache_pkg::core_resp core_resp [cache_pkg::NODES]
);

	// link i runs from node i to node i+1
	cache_pkg::ring_req link_data [cache_pkg::NODES];
	logic [cache_pkg::NODES-1:0] link_valid;
	logic [cache_pkg::NODES-1:0] link_ready;

	for (genvar i = 0; i < cache_pkg::NODES; i++) begin : g_node
		localparam int PREV = (i + cache_pkg::NODES - 1) % cache_pkg::NODES;	// upstream link

		cache_node node (
			.clk,
			.rst_n,
			.core_req_valid(core_req_valid[i]),
			.core_req(core_req[i]),
			.core_ready(core_ready[i]),
			.core_done(core_done[i]),
			.core_resp(core_resp[i]),
			.in_data(link_data[PREV]),
			.in_data_valid(link_valid[PREV]),
			.in_data_ready(link_ready[PREV]),
			.out_data(link_data[i]),
			.out_data_valid(link_valid[i]),
			.out_data_ready(link_ready[i])
		);
	end

endmodule

`default_nettype wire

// File: testbench/ring_cache_assertions.sv
`default_nettype none

module ring_cache_assertions (
	input  logic clk,
	input  logic rst_n,
	input  logic [cache_pkg::NODES-1:0] core_req_valid,
	input  logic [cache_pkg::NODES-1:0] core_ready,
	input  logic [cache_pkg::NODES-1:0] core_done,
	input  cache_pkg::ring_req link_data [cache_pkg::NODES],
	input  logic [cache_pkg::NODES-1:0] link_valid,
	input  logic [cache_pkg::NODES-1:0] link_ready
);

	int fail_count = 0;	// read by the testbench
	logic [cache_pkg::NODES-1:0] pending;	// accepted, done not yet seen

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pending <= '0;
		else
			pending <= (pending | (core_req_valid & core_ready)) & ~core_done;
	end

	for (genvar i = 0; i < cache_pkg::NODES; i++) begin : g_node
		link_hold: assert property (@(posedge clk) disable iff (!rst_n)
			link_valid[i] && !link_ready[i] |=> link_valid[i] && $stable(link_data[i]))
			else begin
				$error("link %0d dropped or changed a stalled packet", i);
				fail_count++;
			end

		done_pending: assert property (@(posedge clk) disable iff (!rst_n)
			core_done[i] |-> pending[i])
			else begin
				$error("node %0d core_done with no pending request", i);
				fail_count++;
			end

		ready_low: assert property (@(posedge clk) disable iff (!rst_n)
			pending[i] |-> !core_ready[i])
			else begin
				$error("node %0d core_ready high while busy", i);
				fail_count++;
			end
	end

endmodule

bind ring_cache_top ring_cache_assertions protocol_check (
	.clk, .rst_n, .core_req_valid, .core_ready, .core_done,
	.link_data, .link_valid, .link_ready
);

`default_nettype wire

// File: testbench/ring_cache_tb.sv
`default_nettype none

module ring_cache_tb;

	localparam int N = cache_pkg::NODES;
	localparam int DIRECTED_OPS = 16;
	localparam int RANDOM_OPS = 300;
	localparam int OP_CYCLES = 200;	// watchdog budget per operation

	logic clk;
	logic rst_n;
	logic [N-1:0] core_req_valid;
	cache_pkg::core_req core_req [N];
	logic [N-1:0] core_ready;
	logic [N-1:0] core_done;
	cache_pkg::core_resp core_resp [N];

	// reference copy of all four caches
	logic m_valid [N][cache_pkg::LINES];
	cache_pkg::addr_tag m_tag [N][cache_pkg::LINES];
	cache_pkg::line m_data [N][cache_pkg::LINES];

	logic [N-1:0] busy;
	logic [cache_pkg::LINES-1:0] index_busy;	// one op per index in flight
	logic exp_found [N];
	logic exp_hit [N];
	logic op_write [N];
	cache_pkg::line exp_data [N];
	cache_pkg::addr_index op_index [N];
	int issue_cycle [N];
	int cycle;
	int seed;

	ring_cache_top uut (
		.clk, .rst_n, .core_req_valid, .core_req, .core_ready, .core_done, .core_resp
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		#((DIRECTED_OPS + RANDOM_OPS + 1) * OP_CYCLES * 8);
		$display("watchdog expired: core requests stopped completing");
		$display("*** TEST FAILED ***");
		$fatal(1, "timeout");
	end

	always @(negedge clk) begin
		if (uut.protocol_check.fail_count != 0) begin
			$display("a ring or core protocol assertion failed");
			$display("*** TEST FAILED ***");
			$fatal(1, "assertion failure");
		end
	end

	task automatic check_value(input logic [31:0] got, input logic [31:0] want,
			input string what);
		if (got !== want) begin
			$display("Fail at %0t: %s, got %h expected %h", $time, what, got, want);
			$display("*** TEST FAILED ***");
			$fatal(1, "value mismatch");
		end
	endtask

	// predict the response and update the caches as the packet would
	task automatic issue_op(input int n, input logic wr,
			input logic [cache_pkg::ADDR_BITS-1:0] addr, input cache_pkg::line wdata);
		cache_pkg::addr_tag t;
		cache_pkg::addr_index x;
		int k;
		int m;
		t = addr[cache_pkg::ADDR_BITS-1:cache_pkg::INDEX_BITS];
		x = addr[cache_pkg::INDEX_BITS-1:0];
		exp_hit[n] = !wr && m_valid[n][x] && m_tag[n][x] == t;
		exp_found[n] = exp_hit[n];
		exp_data[n] = m_data[n][x];
		if (!wr && !exp_hit[n]) begin
			for (k = 1; k < N; k++) begin
				m = (n + k) % N;	// ring order from the origin
				if (!exp_found[n] && m_valid[m][x] && m_tag[m][x] == t) begin
					exp_found[n] = 1'b1;
					exp_data[n] = m_data[m][x];
				end
			end
		end
		if (wr || (exp_found[n] && !exp_hit[n])) begin
			m_valid[n][x] = 1'b1;
			m_tag[n][x] = t;
			m_data[n][x] = wr ? wdata : exp_data[n];
		end
		if (wr) begin
			for (k = 1; k < N; k++) begin
				m = (n + k) % N;
				if (m_valid[m][x] && m_tag[m][x] == t)
					m_valid[m][x] = 1'b0;
			end
		end
		op_write[n] = wr;
		op_index[n] = x;
		issue_cycle[n] = cycle;
		busy[n] = 1'b1;
		index_busy[x] = 1'b1;
		core_req[n].write = wr;
		core_req[n].addr = addr;
		core_req[n].wdata = wdata;
		core_req_valid[n] = 1'b1;
	endtask

	task automatic next_cycle();
		int n;
		@(posedge clk);
		#1;
		cycle++;
		core_req_valid = '0;	// strobe lasts one cycle
		for (n = 0; n < N; n++) begin
			if (core_done[n]) begin
				check_value(32'(busy[n]), 32'd1, "core_done without a pending request");
				if (!op_write[n]) begin
					check_value(32'(core_resp[n].found), 32'(exp_found[n]), "read found");
					if (exp_found[n])
						check_value(core_resp[n].rdata, exp_data[n], "read data");
				end
				if (exp_hit[n])
					check_value(cycle - issue_cycle[n], 1, "local hit latency");
				else
					check_value(32'(cycle - issue_cycle[n] > 4), 1, "ring round trip");
				busy[n] = 1'b0;
				index_busy[op_index[n]] = 1'b0;
			end
		end
	endtask

	task automatic run_op(input int n, input logic wr,
			input logic [cache_pkg::ADDR_BITS-1:0] addr, input cache_pkg::line wdata);
		while (!core_ready[n])
			next_cycle();
		issue_op(n, wr, addr, wdata);
		next_cycle();
		while (busy[n])
			next_cycle();
	endtask

	initial begin
		int n;
		int issued;
		logic [31:0] r;
		logic [cache_pkg::ADDR_BITS-1:0] addr;
		cache_pkg::line d;
		seed = 26084;
		cycle = 0;
		busy = '0;
		index_busy = '0;
		rst_n = 1'b0;
		core_req_valid = '0;
		for (n = 0; n < N; n++) begin
			core_req[n] = '0;
			for (int x = 0; x < cache_pkg::LINES; x++) begin
				m_valid[n][x] = 1'b0;
				m_tag[n][x] = '0;
				m_data[n][x] = '0;
			end
		end
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;

		run_op(0, 1'b1, 8'h0a, 32'h1111_0001);	// tag 1 index 2
		run_op(0, 1'b0, 8'h0a, '0);	// hit on own write
		run_op(2, 1'b0, 8'h0a, '0);	// answered by node 0
		run_op(2, 1'b0, 8'h0a, '0);	// now local
		run_op(3, 1'b1, 8'h0a, 32'h2222_0002);	// kills copies at 0 and 2
		run_op(0, 1'b0, 8'h0a, '0);
		run_op(2, 1'b0, 8'h0a, '0);
		run_op(1, 1'b1, 8'h1d, 32'h3333_0003);
		run_op(1, 1'b1, 8'h2d, 32'h4444_0004);	// evicts the only copy of 8'h1d
		run_op(3, 1'b0, 8'h1d, '0);
		run_op(1, 1'b0, 8'h15, '0);	// never written

		// four misses in flight at once, different indexes
		while (core_ready != '1)
			next_cycle();
		issue_op(0, 1'b0, 8'h2d, '0);
		issue_op(1, 1'b0, 8'h0a, '0);
		issue_op(2, 1'b0, 8'h03, '0);
		issue_op(3, 1'b0, 8'h0e, '0);
		next_cycle();
		while (busy != '0)
			next_cycle();

		issued = 0;
		while (issued < RANDOM_OPS) begin
			r = $random(seed);
			d = $random(seed);
			n = int'(r[1:0]);
			addr = {3'b000, r[9:8], 1'b0, r[5:4]};	// tags 0..3 on indexes 0..3
			if (core_ready[n] && !busy[n] && !index_busy[addr[cache_pkg::INDEX_BITS-1:0]]) begin
				issue_op(n, r[12], addr, d);
				issued++;
			end
			next_cycle();
		end
		while (busy != '0)
			next_cycle();
		repeat (10) next_cycle();	// no late or repeated core_done

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
src/cache_pkg.sv
src/cache_line_store.sv
src/cache_ring.sv
src/cache_node_ctrl.sv
src/cache_node.sv
src/ring_cache_top.sv
testbench/ring_cache_assertions.sv
testbench/ring_cache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP = ring_cache_tb
FILELIST = sim.f
OBJ_DIR = obj_dir
VFLAGS = --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
RUN_FLAGS = +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS)

clean:
	rm -rf $(OBJ_DIR)
